//--- hdl/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // --------------------
    // Instruction encoding
    // --------------------

    typedef enum logic [6:0] {
        op_load      = 7'b0000011,
        op_misc_mem  = 7'b0001111,
        op_op_imm    = 7'b0010011,
        op_auipc     = 7'b0010111,
        op_store     = 7'b0100011,
        op_op        = 7'b0110011,
        op_lui       = 7'b0110111,
        op_branch    = 7'b1100011,
        op_jalr      = 7'b1100111,
        op_jal       = 7'b1101111,
        op_system    = 7'b1110011
    } opcode_t;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    localparam logic [4:0] x0 = 5'd0;

    // imm_zero is the 5-bit CSR immediate in the rs1 field, zero-extended
    typedef enum logic [2:0] {
        imm_i    = 3'd0,
        imm_s    = 3'd1,
        imm_b    = 3'd2,
        imm_u    = 3'd3,
        imm_j    = 3'd4,
        imm_zero = 3'd5
    } imm_fmt_t;

    // --------------------
    // Control encodings
    // --------------------

    // Values follow funct3, so OP and OP-IMM map straight across
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {alu_src1_rs1, alu_src1_pc, alu_src1_zero} alu_src1_t;
    typedef enum logic [1:0] {alu_src2_rs2, alu_src2_imm, alu_src2_four} alu_src2_t;

    typedef enum logic [1:0] {mem_width_byte, mem_width_half, mem_width_word} mem_width_t;

    typedef enum logic [1:0] {csr_op_write, csr_op_set, csr_op_clear} csr_op_t;

    typedef enum logic [1:0] {branch_never, branch_always, branch_cond} branch_op_t;

    localparam logic csr_src_rs1 = 1'b0;
    localparam logic csr_src_imm = 1'b1;

    localparam logic branch_pc_src_pc  = 1'b0;
    localparam logic branch_pc_src_rs1 = 1'b1;

endpackage

//--- hdl/rv32_pipe_pkg.sv
package rv32_pipe_pkg;

    // Decode to execute control bundle
    typedef struct packed {
        logic                     valid;
        logic [4:0]               rs1;
        logic [4:0]               rs2;
        rv32_isa_pkg::alu_op_t    alu_op;
        logic                     alu_sub_sra;
        rv32_isa_pkg::alu_src1_t  alu_src1;
        rv32_isa_pkg::alu_src2_t  alu_src2;
        logic                     mem_read;
        logic                     mem_write;
        rv32_isa_pkg::mem_width_t mem_width;
        logic                     mem_zero_extend;
        logic                     mem_fence;
        logic                     csr_read;
        logic                     csr_write;
        rv32_isa_pkg::csr_op_t    csr_write_op;
        logic                     csr_src;
        rv32_isa_pkg::branch_op_t branch_op;
        logic                     branch_pc_src;
        logic                     branch_predicted_taken;
        logic [4:0]               rd;
        logic                     rd_write;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] imm_value;
        logic [11:0] csr;
    } data_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        write;
        logic [31:0] value;
    } wb_t;

    // Source usage of the instruction still sitting in decode
    typedef struct packed {
        logic [4:0] rs1;
        logic       rs1_read;
        logic [4:0] rs2;
        logic       rs2_read;
        logic       mem_fence;
    } src_use_t;

endpackage

//--- hdl/rv32_regs.sv
module rv32_regs (
    input  logic               clk,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    input  rv32_pipe_pkg::wb_t wb,
    output logic [31:0]        rs1_value,
    output logic [31:0]        rs2_value
);

    logic [31:0] regs [1:31];

    // x0 reads zero, and a same-cycle writeback bypasses the array
    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == rv32_isa_pkg::x0) begin
            return '0;
        end else if (wb.write && wb.rd == idx) begin
            return wb.value;
        end else begin
            return regs[idx];
        end
    endfunction

    always_comb begin
        rs1_value = read_reg(rs1);
        rs2_value = read_reg(rs2);
    end

    always_ff @(posedge clk) begin
        if (wb.write && wb.rd != rv32_isa_pkg::x0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // A value written to a register reads back on the next cycle
    write_reads_back: assert property (@(posedge clk)
        (wb.write && wb.rd != rv32_isa_pkg::x0)
        |=> (rs1 != $past(wb.rd) || (wb.write && wb.rd == rs1)
             || rs1_value == $past(wb.value))
            && (rs2 != $past(wb.rd) || (wb.write && wb.rd == rs2)
                || rs2_value == $past(wb.value)));

endmodule

//--- hdl/rv32_control_unit.sv
module rv32_control_unit (
    input  logic [31:0]            instr,
    output rv32_pipe_pkg::ctrl_t    ctrl,
    output rv32_pipe_pkg::src_use_t src_use,
    output rv32_isa_pkg::imm_fmt_t  imm_fmt
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       legal;
    logic       rs1_read;
    logic       rs2_read;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        ctrl = '0;
        ctrl.rs1 = rs1;
        ctrl.rs2 = rs2;
        ctrl.rd = rd;
        ctrl.alu_op = rv32_isa_pkg::alu_add;
        ctrl.alu_src1 = rv32_isa_pkg::alu_src1_rs1;
        ctrl.alu_src2 = rv32_isa_pkg::alu_src2_rs2;
        ctrl.mem_width = rv32_isa_pkg::mem_width_word;
        ctrl.csr_write_op = rv32_isa_pkg::csr_op_write;
        ctrl.csr_src = rv32_isa_pkg::csr_src_rs1;
        ctrl.branch_op = rv32_isa_pkg::branch_never;
        ctrl.branch_pc_src = rv32_isa_pkg::branch_pc_src_pc;
        imm_fmt = rv32_isa_pkg::imm_i;
        legal = 1'b1;
        rs1_read = 1'b0;
        rs2_read = 1'b0;

        case (opcode)
            rv32_isa_pkg::op_lui: begin
                ctrl.alu_src1 = rv32_isa_pkg::alu_src1_zero;
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_imm;
                ctrl.rd_write = 1'b1;
                imm_fmt = rv32_isa_pkg::imm_u;
            end
            rv32_isa_pkg::op_auipc: begin
                ctrl.alu_src1 = rv32_isa_pkg::alu_src1_pc;
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_imm;
                ctrl.rd_write = 1'b1;
                imm_fmt = rv32_isa_pkg::imm_u;
            end
            rv32_isa_pkg::op_jal: begin
                // Link value pc+4 comes out of the ALU, target from pc+imm
                ctrl.alu_src1 = rv32_isa_pkg::alu_src1_pc;
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_four;
                ctrl.branch_op = rv32_isa_pkg::branch_always;
                ctrl.rd_write = 1'b1;
                imm_fmt = rv32_isa_pkg::imm_j;
            end
            rv32_isa_pkg::op_jalr: begin
                legal = (funct3 == 3'b000);
                rs1_read = 1'b1;
                ctrl.alu_src1 = rv32_isa_pkg::alu_src1_pc;
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_four;
                ctrl.branch_op = rv32_isa_pkg::branch_always;
                ctrl.branch_pc_src = rv32_isa_pkg::branch_pc_src_rs1;
                ctrl.rd_write = 1'b1;
            end
            rv32_isa_pkg::op_branch: begin
                // alu_op carries the branch funct3 so execute can pick the compare
                legal = (funct3[2:1] != 2'b01);
                rs1_read = 1'b1;
                rs2_read = 1'b1;
                ctrl.alu_op = rv32_isa_pkg::alu_op_t'(funct3);
                ctrl.branch_op = rv32_isa_pkg::branch_cond;
                imm_fmt = rv32_isa_pkg::imm_b;
            end
            rv32_isa_pkg::op_load: begin
                legal = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
                rs1_read = 1'b1;
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_imm;
                ctrl.mem_read = 1'b1;
                ctrl.mem_width = rv32_isa_pkg::mem_width_t'(funct3[1:0]);
                ctrl.mem_zero_extend = funct3[2];
                ctrl.rd_write = 1'b1;
            end
            rv32_isa_pkg::op_store: begin
                legal = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
                rs1_read = 1'b1;
                rs2_read = 1'b1;
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_imm;
                ctrl.mem_write = 1'b1;
                ctrl.mem_width = rv32_isa_pkg::mem_width_t'(funct3[1:0]);
                imm_fmt = rv32_isa_pkg::imm_s;
            end
            rv32_isa_pkg::op_op_imm: begin
                rs1_read = 1'b1;
                ctrl.alu_op = rv32_isa_pkg::alu_op_t'(funct3);
                ctrl.alu_src2 = rv32_isa_pkg::alu_src2_imm;
                ctrl.rd_write = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = (funct7 == rv32_isa_pkg::funct7_base);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == rv32_isa_pkg::funct7_base)
                         || (funct7 == rv32_isa_pkg::funct7_alt);
                    ctrl.alu_sub_sra = funct7[5];
                end
            end
            rv32_isa_pkg::op_op: begin
                rs1_read = 1'b1;
                rs2_read = 1'b1;
                ctrl.alu_op = rv32_isa_pkg::alu_op_t'(funct3);
                ctrl.rd_write = 1'b1;
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                if (funct7 == rv32_isa_pkg::funct7_alt) begin
                    legal = (funct3 == 3'b000) || (funct3 == 3'b101);
                    ctrl.alu_sub_sra = 1'b1;
                end else begin
                    legal = (funct7 == rv32_isa_pkg::funct7_base);
                end
            end
            rv32_isa_pkg::op_misc_mem: begin
                legal = (funct3 == 3'b000);
                ctrl.mem_fence = 1'b1;
            end
            rv32_isa_pkg::op_system: begin
                legal = (funct3[1:0] != 2'b00);
                rs1_read = !funct3[2];
                ctrl.csr_read = 1'b1;
                ctrl.csr_src = funct3[2];
                ctrl.rd_write = 1'b1;
                imm_fmt = rv32_isa_pkg::imm_zero;
                case (funct3[1:0])
                    2'b10: ctrl.csr_write_op = rv32_isa_pkg::csr_op_set;
                    2'b11: ctrl.csr_write_op = rv32_isa_pkg::csr_op_clear;
                    default: ctrl.csr_write_op = rv32_isa_pkg::csr_op_write;
                endcase
                // Set and clear with a zero source leave the CSR untouched
                ctrl.csr_write = (funct3[1:0] == 2'b01) || (rs1 != rv32_isa_pkg::x0);
            end
            default: legal = 1'b0;
        endcase

        ctrl.valid = legal;
        if (!legal) begin
            rs1_read = 1'b0;
            rs2_read = 1'b0;
            ctrl.mem_read = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.mem_fence = 1'b0;
            ctrl.csr_read = 1'b0;
            ctrl.csr_write = 1'b0;
            ctrl.branch_op = rv32_isa_pkg::branch_never;
            ctrl.rd_write = 1'b0;
        end
    end

    always_comb begin
        src_use.rs1 = rs1;
        src_use.rs1_read = rs1_read;
        src_use.rs2 = rs2;
        src_use.rs2_read = rs2_read;
        src_use.mem_fence = ctrl.mem_fence;
    end

endmodule

//--- hdl/rv32_imm_mux.sv
module rv32_imm_mux (
    input  rv32_isa_pkg::imm_fmt_t imm_fmt,
    input  logic [31:0]            instr,
    output logic [31:0]            imm_value
);

    always_comb begin
        case (imm_fmt)
            rv32_isa_pkg::imm_i: imm_value = {{21{instr[31]}}, instr[30:20]};
            rv32_isa_pkg::imm_s: imm_value = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            rv32_isa_pkg::imm_b: begin
                imm_value = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv32_isa_pkg::imm_u: imm_value = {instr[31:12], 12'b0};
            rv32_isa_pkg::imm_j: begin
                imm_value = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            rv32_isa_pkg::imm_zero: imm_value = {27'b0, instr[19:15]};
            default: imm_value = '0;
        endcase
    end

endmodule

//--- hdl/rv32_decode.sv
module rv32_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    branch_predicted_taken,
    input  logic [31:0]             pc,
    input  logic [31:0]             instr,
    input  rv32_pipe_pkg::wb_t      wb,
    output rv32_pipe_pkg::src_use_t src_use,
    output rv32_pipe_pkg::ctrl_t    ctrl,
    output rv32_pipe_pkg::data_t    data
);

    logic [4:0]             rs1_idx;
    logic [4:0]             rs2_idx;
    logic [11:0]            csr_addr;
    logic [31:0]            rs1_value;
    logic [31:0]            rs2_value;
    logic [31:0]            imm_value;
    rv32_isa_pkg::imm_fmt_t imm_fmt;
    rv32_pipe_pkg::ctrl_t   dec_ctrl;
    rv32_pipe_pkg::ctrl_t   next_ctrl;

    // Clears everything that could cause a side effect further down
    function automatic rv32_pipe_pkg::ctrl_t bubble(input rv32_pipe_pkg::ctrl_t c);
        rv32_pipe_pkg::ctrl_t b;
        b = c;
        b.valid = 1'b0;
        b.mem_read = 1'b0;
        b.mem_write = 1'b0;
        b.csr_read = 1'b0;
        b.csr_write = 1'b0;
        b.branch_op = rv32_isa_pkg::branch_never;
        b.rd_write = 1'b0;
        return b;
    endfunction

    assign rs1_idx  = instr[19:15];
    assign rs2_idx  = instr[24:20];
    assign csr_addr = instr[31:20];

    rv32_regs regs_inst (
        .clk(clk),
        .rs1(rs1_idx),
        .rs2(rs2_idx),
        .wb(wb),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    rv32_control_unit control_unit_inst (
        .instr(instr),
        .ctrl(dec_ctrl),
        .src_use(src_use),
        .imm_fmt(imm_fmt)
    );

    rv32_imm_mux imm_mux_inst (
        .imm_fmt(imm_fmt),
        .instr(instr),
        .imm_value(imm_value)
    );

    always_comb begin
        next_ctrl = dec_ctrl;
        next_ctrl.branch_predicted_taken = branch_predicted_taken;
    end

    // --------------------
    // Stage register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= bubble(ctrl);
        end else if (!stall) begin
            ctrl <= flush ? bubble(next_ctrl) : next_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            data <= '{pc: pc, rs1_value: rs1_value, rs2_value: rs2_value,
                      imm_value: imm_value, csr: csr_addr};
        end
    end

    no_store_branch_writeback: assert property (@(posedge clk) disable iff (reset)
        !stall |=> !(ctrl.valid && ctrl.rd_write)
                   || !($past(instr[6:0]) inside {rv32_isa_pkg::op_store,
                                                  rv32_isa_pkg::op_branch}));

    hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(ctrl) && $stable(data));

endmodule

//--- hdl/rv32_hazard.sv
module rv32_hazard (
    input  rv32_pipe_pkg::src_use_t src_use,
    input  rv32_pipe_pkg::ctrl_t    ex_ctrl,
    input  logic                    stall,
    input  logic                    flush,
    output logic                    decode_stall,
    output logic                    decode_flush,
    output logic                    fetch_stall
);

    logic ex_load;
    logic rs1_match;
    logic rs2_match;
    logic load_use;

    // A load in execute has no result until memory, so a reader must wait
    assign ex_load = ex_ctrl.valid && ex_ctrl.mem_read && ex_ctrl.rd_write
                  && ex_ctrl.rd != rv32_isa_pkg::x0;

    assign rs1_match = src_use.rs1_read && src_use.rs1 == ex_ctrl.rd;
    assign rs2_match = src_use.rs2_read && src_use.rs2 == ex_ctrl.rd;
    assign load_use  = ex_load && (rs1_match || rs2_match);

    assign decode_stall = stall;
    assign decode_flush = flush || (load_use && !stall);
    assign fetch_stall  = stall || (load_use && !flush);

endmodule

//--- hdl/rv32_decode_top.sv
module rv32_decode_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 branch_predicted_taken,
    input  logic [31:0]          pc,
    input  logic [31:0]          instr,
    input  rv32_pipe_pkg::wb_t   wb,
    output logic                 fetch_stall,
    output rv32_pipe_pkg::ctrl_t ctrl,
    output rv32_pipe_pkg::data_t data
);

    logic                    decode_stall;
    logic                    decode_flush;
    rv32_pipe_pkg::src_use_t src_use;

    rv32_decode decode_inst (
        .clk(clk),
        .reset(reset),
        .stall(decode_stall),
        .flush(decode_flush),
        .branch_predicted_taken(branch_predicted_taken),
        .pc(pc),
        .instr(instr),
        .wb(wb),
        .src_use(src_use),
        .ctrl(ctrl),
        .data(data)
    );

    // The stage output register is what execute is working on now
    rv32_hazard hazard_inst (
        .src_use(src_use),
        .ex_ctrl(ctrl),
        .stall(stall),
        .flush(flush),
        .decode_stall(decode_stall),
        .decode_flush(decode_flush),
        .fetch_stall(fetch_stall)
    );

endmodule

//--- test/rv32_decode_tb.sv
module rv32_decode_tb;

    // The tests take about 70 cycles, so 400 leaves a wide margin
    localparam int max_cycles = 400;
    localparam logic [31:0] nop_word = 32'h00000013;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    logic                 flush;
    logic                 branch_predicted_taken;
    logic [31:0]          pc;
    logic [31:0]          instr;
    rv32_pipe_pkg::wb_t   wb;
    logic                 fetch_stall;
    rv32_pipe_pkg::ctrl_t ctrl;
    rv32_pipe_pkg::data_t data;

    int          errors;
    int          checks;
    int          cycles;
    integer      seed;
    logic [31:0] model [0:31];

    rv32_decode_top rv32_decode_top_inst (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .branch_predicted_taken(branch_predicted_taken),
        .pc(pc),
        .instr(instr),
        .wb(wb),
        .fetch_stall(fetch_stall),
        .ctrl(ctrl),
        .data(data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not complete within %0d cycles", max_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // --------------------
    // Instruction encoders
    // --------------------

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // A plain register-writing instruction that each test adjusts
    function automatic rv32_pipe_pkg::ctrl_t base_ctrl(input logic [31:0] word);
        rv32_pipe_pkg::ctrl_t c;
        c = '0;
        c.valid = 1'b1;
        c.rs1 = word[19:15];
        c.rs2 = word[24:20];
        c.rd = word[11:7];
        c.rd_write = 1'b1;
        c.alu_op = rv32_isa_pkg::alu_add;
        c.alu_src1 = rv32_isa_pkg::alu_src1_rs1;
        c.alu_src2 = rv32_isa_pkg::alu_src2_rs2;
        c.mem_width = rv32_isa_pkg::mem_width_word;
        c.csr_write_op = rv32_isa_pkg::csr_op_write;
        c.branch_op = rv32_isa_pkg::branch_never;
        return c;
    endfunction

    function automatic rv32_pipe_pkg::data_t exp_data(input logic [31:0] word,
                                                      input logic [31:0] imm);
        rv32_pipe_pkg::data_t d;
        d.pc = pc;
        d.rs1_value = model[word[19:15]];
        d.rs2_value = model[word[24:20]];
        d.imm_value = imm;
        d.csr = word[31:20];
        return d;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_ctrl(input string name, input rv32_pipe_pkg::ctrl_t exp,
                              input rv32_pipe_pkg::ctrl_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: ctrl expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input rv32_pipe_pkg::data_t exp,
                              input rv32_pipe_pkg::data_t act, input logic check_imm);
        rv32_pipe_pkg::data_t care;
        care = '1;
        if (!check_imm) begin
            care.imm_value = '0;
        end
        checks++;
        if (((exp ^ act) & care) !== '0) begin
            errors++;
            $display("ERROR %s: data expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_bubble(input string name);
        check_bit({name, " valid"}, 1'b0, ctrl.valid);
        check_bit({name, " mem_read"}, 1'b0, ctrl.mem_read);
        check_bit({name, " mem_write"}, 1'b0, ctrl.mem_write);
        check_bit({name, " csr_read"}, 1'b0, ctrl.csr_read);
        check_bit({name, " csr_write"}, 1'b0, ctrl.csr_write);
        check_bit({name, " rd_write"}, 1'b0, ctrl.rd_write);
        check_bit({name, " branch_never"}, 1'b1, ctrl.branch_op == rv32_isa_pkg::branch_never);
    endtask

    task automatic check_result(input string name, input rv32_pipe_pkg::ctrl_t c,
                                input logic [31:0] imm, input logic check_imm);
        check_ctrl(name, c, ctrl);
        check_data(name, exp_data(instr, imm), data, check_imm);
    endtask

    // --------------------
    // Drivers
    // --------------------

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic issue(input logic [31:0] word);
        instr = word;
        pc = pc + 32'd4;
    endtask

    task automatic decode(input logic [31:0] word);
        issue(word);
        tick();
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
        wb = '{rd: idx, write: 1'b1, value: value};
        if (idx != 5'd0) begin
            model[idx] = value;
        end
        tick();
        wb.write = 1'b0;
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic test_reset();
        reset = 1'b1;
        tick();
        tick();
        reset = 1'b0;
        check_bubble("reset");
        check_bit("reset idle fetch_stall", 1'b0, fetch_stall);
        stall = 1'b1;
        #5;
        check_bit("reset stall fetch_stall", 1'b1, fetch_stall);
        tick();
        stall = 1'b0;
        flush = 1'b1;
        #5;
        check_bit("reset flush fetch_stall", 1'b0, fetch_stall);
        tick();
        flush = 1'b0;
    endtask

    task automatic test_regfile();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            write_reg(i[4:0], $random(seed));
        end
        w = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5);
        decode(w);
        check_data("regfile x1 x2", exp_data(w, '0), data, 1'b0);
        w = enc_r(7'b0000000, 5'd31, 5'd17, 3'b000, 5'd6);
        decode(w);
        check_data("regfile x17 x31", exp_data(w, '0), data, 1'b0);
        w = enc_r(7'b0000000, 5'd4, 5'd0, 3'b000, 5'd7);
        decode(w);
        check_data("regfile x0", exp_data(w, '0), data, 1'b0);
        // Writeback to x3 lands on the same edge that registers its read
        w = enc_r(7'b0000000, 5'd1, 5'd3, 3'b000, 5'd8);
        issue(w);
        write_reg(5'd3, $random(seed));
        check_data("regfile write-through", exp_data(w, '0), data, 1'b0);
    endtask

    task automatic test_alu();
        rv32_pipe_pkg::ctrl_t c;
        decode(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
        check_result("add", base_ctrl(instr), '0, 1'b0);
        decode(enc_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
        c = base_ctrl(instr);
        c.alu_sub_sra = 1'b1;
        check_result("sub", c, '0, 1'b0);
        decode(enc_r(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd5));
        c = base_ctrl(instr);
        c.alu_op = rv32_isa_pkg::alu_srl;
        c.alu_sub_sra = 1'b1;
        check_result("sra", c, '0, 1'b0);
        decode(enc_i(12'hffb, 5'd1, 3'b010, 5'd6, rv32_isa_pkg::op_op_imm));
        c = base_ctrl(instr);
        c.alu_op = rv32_isa_pkg::alu_slt;
        c.alu_src2 = rv32_isa_pkg::alu_src2_imm;
        check_result("slti", c, sext12(12'hffb), 1'b1);
        decode(enc_u(20'habcde, 5'd7, rv32_isa_pkg::op_lui));
        c = base_ctrl(instr);
        c.alu_src1 = rv32_isa_pkg::alu_src1_zero;
        c.alu_src2 = rv32_isa_pkg::alu_src2_imm;
        check_result("lui", c, {20'habcde, 12'h000}, 1'b1);
        decode(enc_u(20'h12345, 5'd8, rv32_isa_pkg::op_auipc));
        c.rs1 = instr[19:15];
        c.rs2 = instr[24:20];
        c.rd = 5'd8;
        c.alu_src1 = rv32_isa_pkg::alu_src1_pc;
        check_result("auipc", c, {20'h12345, 12'h000}, 1'b1);
    endtask

    task automatic test_mem_branch_system();
        rv32_pipe_pkg::ctrl_t c;
        decode(enc_i(12'hffc, 5'd1, 3'b000, 5'd9, rv32_isa_pkg::op_load));
        c = base_ctrl(instr);
        c.alu_src2 = rv32_isa_pkg::alu_src2_imm;
        c.mem_read = 1'b1;
        c.mem_width = rv32_isa_pkg::mem_width_byte;
        check_result("lb", c, sext12(12'hffc), 1'b1);
        decode(enc_i(12'h006, 5'd2, 3'b101, 5'd10, rv32_isa_pkg::op_load));
        c = base_ctrl(instr);
        c.alu_src2 = rv32_isa_pkg::alu_src2_imm;
        c.mem_read = 1'b1;
        c.mem_width = rv32_isa_pkg::mem_width_half;
        c.mem_zero_extend = 1'b1;
        check_result("lhu", c, 32'd6, 1'b1);
        decode(enc_s(12'h7f8, 5'd3, 5'd4, 3'b010));
        c = base_ctrl(instr);
        c.alu_src2 = rv32_isa_pkg::alu_src2_imm;
        c.mem_write = 1'b1;
        c.rd_write = 1'b0;
        check_result("sw", c, 32'h000007f8, 1'b1);
        decode(enc_b(13'h1ff0, 5'd2, 5'd1, 3'b000));
        c = base_ctrl(instr);
        c.branch_op = rv32_isa_pkg::branch_cond;
        c.rd_write = 1'b0;
        check_result("beq", c, 32'hfffffff0, 1'b1);
        branch_predicted_taken = 1'b1;
        decode(enc_j(21'h1ff802, 5'd1));
        branch_predicted_taken = 1'b0;
        c = base_ctrl(instr);
        c.alu_src1 = rv32_isa_pkg::alu_src1_pc;
        c.alu_src2 = rv32_isa_pkg::alu_src2_four;
        c.branch_op = rv32_isa_pkg::branch_always;
        c.branch_predicted_taken = 1'b1;
        check_result("jal", c, 32'hfffff802, 1'b1);
        decode(enc_i(12'h008, 5'd5, 3'b000, 5'd1, rv32_isa_pkg::op_jalr));
        c = base_ctrl(instr);
        c.alu_src1 = rv32_isa_pkg::alu_src1_pc;
        c.alu_src2 = rv32_isa_pkg::alu_src2_four;
        c.branch_op = rv32_isa_pkg::branch_always;
        c.branch_pc_src = rv32_isa_pkg::branch_pc_src_rs1;
        check_result("jalr", c, 32'd8, 1'b1);
        decode(enc_i(12'h300, 5'd1, 3'b001, 5'd3, rv32_isa_pkg::op_system));
        c = base_ctrl(instr);
        c.csr_read = 1'b1;
        c.csr_write = 1'b1;
        check_result("csrrw", c, '0, 1'b0);
        decode(enc_i(12'h341, 5'd21, 3'b110, 5'd4, rv32_isa_pkg::op_system));
        c = base_ctrl(instr);
        c.csr_read = 1'b1;
        c.csr_write = 1'b1;
        c.csr_write_op = rv32_isa_pkg::csr_op_set;
        c.csr_src = rv32_isa_pkg::csr_src_imm;
        check_result("csrrsi", c, 32'd21, 1'b1);
        decode(enc_i(12'hc00, 5'd0, 3'b010, 5'd5, rv32_isa_pkg::op_system));
        c = base_ctrl(instr);
        c.csr_read = 1'b1;
        c.csr_write_op = rv32_isa_pkg::csr_op_set;
        check_result("csrrs x0", c, '0, 1'b0);
        decode(enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, rv32_isa_pkg::op_misc_mem));
        c = base_ctrl(instr);
        c.mem_fence = 1'b1;
        c.rd_write = 1'b0;
        check_result("fence", c, '0, 1'b0);
        decode(32'hffffffff);
        check_bubble("illegal");
        check_bit("illegal mem_fence", 1'b0, ctrl.mem_fence);
    endtask

    task automatic test_stall_flush();
        rv32_pipe_pkg::ctrl_t held_ctrl;
        rv32_pipe_pkg::data_t held_data;
        rv32_pipe_pkg::ctrl_t c;
        decode(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd11));
        held_ctrl = base_ctrl(instr);
        held_data = exp_data(instr, '0);
        stall = 1'b1;
        issue(enc_r(7'b0100000, 5'd4, 5'd3, 3'b000, 5'd12));
        #5;
        check_bit("stall fetch_stall", 1'b1, fetch_stall);
        for (int i = 0; i < 2; i++) begin
            tick();
            check_ctrl("stall hold", held_ctrl, ctrl);
            check_data("stall hold", held_data, data, 1'b0);
        end
        stall = 1'b0;
        flush = 1'b1;
        #5;
        check_bit("flush fetch_stall", 1'b0, fetch_stall);
        tick();
        check_bubble("flush");
        flush = 1'b0;
        decode(enc_i(12'd100, 5'd2, 3'b000, 5'd13, rv32_isa_pkg::op_op_imm));
        c = base_ctrl(instr);
        c.alu_src2 = rv32_isa_pkg::alu_src2_imm;
        check_result("after flush", c, 32'd100, 1'b1);
    endtask

    task automatic test_load_use();
        decode(enc_i(12'h000, 5'd1, 3'b010, 5'd5, rv32_isa_pkg::op_load));
        issue(enc_r(7'b0000000, 5'd2, 5'd5, 3'b000, 5'd6));
        #5;
        check_bit("load-use fetch_stall", 1'b1, fetch_stall);
        tick();
        check_bubble("load-use");
        check_bit("load-use released", 1'b0, fetch_stall);
        tick();
        check_result("load-use add", base_ctrl(instr), '0, 1'b0);

        decode(enc_i(12'h004, 5'd1, 3'b010, 5'd0, rv32_isa_pkg::op_load));
        issue(enc_r(7'b0000000, 5'd2, 5'd0, 3'b000, 5'd6));
        #5;
        check_bit("load x0 fetch_stall", 1'b0, fetch_stall);
        tick();
        check_result("load x0 add", base_ctrl(instr), '0, 1'b0);

        decode(enc_i(12'h000, 5'd1, 3'b010, 5'd5, rv32_isa_pkg::op_load));
        issue(enc_r(7'b0000000, 5'd8, 5'd7, 3'b000, 5'd6));
        #5;
        check_bit("independent fetch_stall", 1'b0, fetch_stall);
        tick();
        check_result("independent add", base_ctrl(instr), '0, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        branch_predicted_taken = 1'b0;
        pc = 32'h00001000;
        instr = nop_word;
        wb = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seed = 32'hb19d0548;
        model[0] = '0;

        test_reset();
        test_regfile();
        test_alu();
        test_mem_branch_system();
        test_stall_flush();
        test_load_use();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/rv32_isa_pkg.sv
hdl/rv32_pipe_pkg.sv
hdl/rv32_regs.sv
hdl/rv32_control_unit.sv
hdl/rv32_imm_mux.sv
hdl/rv32_decode.sv
hdl/rv32_hazard.sv
hdl/rv32_decode_top.sv
test/rv32_decode_tb.sv

//--- Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = rv32_decode_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors
FAIL_MSG  = Finished with errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
